//--- common/axil_pkg.sv
// AXI4-Lite widths, response codes and channel structs; imported by the slave, top and testbench
`default_nettype none

package axil_pkg;

	// Bus geometry fixed by the four-word register map
	localparam int AXIL_ADDR_W = 4;
	localparam int AXIL_DATA_W = 32;
	localparam int AXIL_STRB_W = AXIL_DATA_W / 8;
	localparam int AXIL_RESP_W = 2;

	// Only OKAY is ever returned
	localparam logic [AXIL_RESP_W-1:0] RESP_OKAY = 2'b00;

	// Everything the master drives
	typedef struct packed {
		logic [AXIL_ADDR_W-1:0] awaddr;
		logic                   awvalid;
		logic [AXIL_DATA_W-1:0] wdata;
		logic [AXIL_STRB_W-1:0] wstrb;
		logic                   wvalid;
		logic                   bready;
		logic [AXIL_ADDR_W-1:0] araddr;
		logic                   arvalid;
		logic                   rready;
	} axil_req_t;

	// Everything the slave drives
	typedef struct packed {
		logic                   awready;
		logic                   wready;
		logic [AXIL_RESP_W-1:0] bresp;
		logic                   bvalid;
		logic                   arready;
		logic [AXIL_DATA_W-1:0] rdata;
		logic [AXIL_RESP_W-1:0] rresp;
		logic                   rvalid;
	} axil_rsp_t;

endpackage

`default_nettype wire

//--- common/regmap_pkg.sv
// Register map of the peripheral and the register-file write request; shared by slave and regs
`default_nettype none

package regmap_pkg;

	// Word size of the register file
	localparam int REG_DATA_W = 32;
	localparam int REG_STRB_W = REG_DATA_W / 8;

	// Four registers indexed by address bits [3:2]
	localparam int REG_IDX_W = 2;

	localparam logic [REG_IDX_W-1:0] REG_ID      = 2'd0;
	localparam logic [REG_IDX_W-1:0] REG_SCRATCH = 2'd1;
	localparam logic [REG_IDX_W-1:0] REG_CONTROL = 2'd2;
	localparam logic [REG_IDX_W-1:0] REG_COUNTER = 2'd3;

	// Constant returned by the read-only ID register
	localparam logic [REG_DATA_W-1:0] ID_VALUE = 32'hA11C_0001;

	// CONTROL bit fields
	localparam int CTRL_CNT_EN_BIT = 0;

	// Single-cycle write into the register file
	typedef struct packed {
		logic                  en;
		logic [REG_IDX_W-1:0]  idx;
		logic [REG_DATA_W-1:0] data;
		logic [REG_STRB_W-1:0] strb;
	} reg_wr_t;

endpackage

`default_nettype wire

//--- axi_lite_slave/axi_lite_slave.sv
// AXI4-Lite slave that turns bus writes and reads into register-file accesses, used by periph_top
`timescale 1ns/1ps
`default_nettype none

module axi_lite_slave
	import axil_pkg::*;
	import regmap_pkg::*;
(
	input  wire                   clk,
	input  wire                   resetn,
	input  wire axil_req_t        axi_req,
	output axil_rsp_t             axi_rsp,
	output reg_wr_t               wr_req,
	output logic [REG_IDX_W-1:0]  rd_idx,
	input  wire [REG_DATA_W-1:0]  rd_data
);

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_t;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} rd_state_t;

	wr_state_t wr_state;
	wr_state_t wr_state_next;
	rd_state_t rd_state;
	rd_state_t rd_state_next;

	logic aw_hs;
	logic w_hs;
	logic b_hs;
	logic ar_hs;
	logic r_hs;

	// Word index latched at the address handshakes
	logic [REG_IDX_W-1:0] aw_idx;
	logic [REG_IDX_W-1:0] ar_idx;

	logic                   rvalid_q;
	logic [AXIL_DATA_W-1:0] rdata_q;

	// Ready and bvalid come straight from state
	always_comb begin
		axi_rsp.awready = (wr_state == WR_ADDR);
		axi_rsp.wready  = (wr_state == WR_DATA);
		axi_rsp.bresp   = RESP_OKAY;
		axi_rsp.bvalid  = (wr_state == WR_RESP);
		axi_rsp.arready = (rd_state == RD_ADDR);
		axi_rsp.rdata   = rdata_q;
		axi_rsp.rresp   = RESP_OKAY;
		axi_rsp.rvalid  = rvalid_q;
	end

	assign aw_hs = axi_req.awvalid && axi_rsp.awready;
	assign w_hs  = axi_req.wvalid && axi_rsp.wready;
	assign b_hs  = axi_rsp.bvalid && axi_req.bready;
	assign ar_hs = axi_req.arvalid && axi_rsp.arready;
	assign r_hs  = rvalid_q && axi_req.rready;

	// Write FSM
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wr_state <= WR_IDLE;
		end else begin
			wr_state <= wr_state_next;
		end
	end

	always_comb begin
		wr_state_next = wr_state;
		case (wr_state)
			WR_IDLE: if (axi_req.awvalid) wr_state_next = WR_ADDR;
			WR_ADDR: if (aw_hs) wr_state_next = WR_DATA;
			WR_DATA: if (w_hs) wr_state_next = WR_RESP;
			WR_RESP: if (b_hs) wr_state_next = WR_IDLE;
			default: wr_state_next = WR_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (aw_hs) begin
			aw_idx <= axi_req.awaddr[AXIL_ADDR_W-1:2];
		end
	end

	// One-cycle write request that lines up with the first bvalid cycle
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wr_req <= '0;
		end else begin
			wr_req.en <= w_hs && (axi_req.wstrb != '0);
			if (w_hs) begin
				wr_req.idx  <= aw_idx;
				wr_req.data <= axi_req.wdata;
				wr_req.strb <= axi_req.wstrb;
			end
		end
	end

	// Read FSM
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			rd_state <= RD_IDLE;
		end else begin
			rd_state <= rd_state_next;
		end
	end

	always_comb begin
		rd_state_next = rd_state;
		case (rd_state)
			RD_IDLE: if (axi_req.arvalid) rd_state_next = RD_ADDR;
			RD_ADDR: if (ar_hs) rd_state_next = RD_DATA;
			RD_DATA: if (r_hs) rd_state_next = RD_IDLE;
			default: rd_state_next = RD_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (ar_hs) begin
			ar_idx <= axi_req.araddr[AXIL_ADDR_W-1:2];
		end
	end

	assign rd_idx = ar_idx;

	// First cycle in RD_DATA samples the register and rvalid then holds it
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			rvalid_q <= 1'b0;
		end else if (r_hs) begin
			rvalid_q <= 1'b0;
		end else if (rd_state == RD_DATA) begin
			rvalid_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_state == RD_DATA && !rvalid_q) begin
			rdata_q <= rd_data;
		end
	end

	// Response must be held until the master takes it
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
		axi_rsp.bvalid && !axi_req.bready |=> axi_rsp.bvalid);

	a_rvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
		axi_rsp.rvalid && !axi_req.rready |=> axi_rsp.rvalid && $stable(axi_rsp.rdata));

	// Each accepted beat writes the regs at most once
	a_wr_pulse: assert property (@(posedge clk) disable iff (!resetn)
		wr_req.en |=> !wr_req.en);

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
// Peripheral register file with ID, SCRATCH, CONTROL and COUNTER, written and read by the slave
`timescale 1ns/1ps
`default_nettype none

module reg_file
	import regmap_pkg::*;
(
	input  wire                    clk,
	input  wire                    resetn,
	input  wire reg_wr_t           wr_req,
	input  wire [REG_IDX_W-1:0]    rd_idx,
	output logic [REG_DATA_W-1:0]  rd_data
);

	logic [REG_DATA_W-1:0] scratch;
	logic [REG_DATA_W-1:0] control;
	logic [REG_DATA_W-1:0] counter;

	logic wr_scratch;
	logic wr_control;
	logic wr_counter;
	logic cnt_en;

	// Replace only the bytes whose strobe is set
	function automatic logic [REG_DATA_W-1:0] merge_strb(
		input logic [REG_DATA_W-1:0] old_val,
		input logic [REG_DATA_W-1:0] new_val,
		input logic [REG_STRB_W-1:0] strb
	);
		logic [REG_DATA_W-1:0] res;
		res = old_val;
		for (int i = 0; i < REG_STRB_W; i++) begin
			if (strb[i]) begin
				res[i*8 +: 8] = new_val[i*8 +: 8];
			end
		end
		return res;
	endfunction

	// ID has no write decode at all
	assign wr_scratch = wr_req.en && (wr_req.idx == REG_SCRATCH);
	assign wr_control = wr_req.en && (wr_req.idx == REG_CONTROL);
	assign wr_counter = wr_req.en && (wr_req.idx == REG_COUNTER);

	assign cnt_en = control[CTRL_CNT_EN_BIT];

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			scratch <= '0;
			control <= '0;
		end else begin
			if (wr_scratch) begin
				scratch <= merge_strb(scratch, wr_req.data, wr_req.strb);
			end
			if (wr_control) begin
				control <= merge_strb(control, wr_req.data, wr_req.strb);
			end
		end
	end

	// Bus load takes priority over counting
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			counter <= '0;
		end else if (wr_counter) begin
			counter <= merge_strb(counter, wr_req.data, wr_req.strb);
		end else if (cnt_en) begin
			counter <= counter + 1'b1;
		end
	end

	always_comb begin
		case (rd_idx)
			REG_ID:      rd_data = ID_VALUE;
			REG_SCRATCH: rd_data = scratch;
			REG_CONTROL: rd_data = control;
			REG_COUNTER: rd_data = counter;
			default:     rd_data = '0;
		endcase
	end

	// Idle counter must hold its value
	a_cnt_frozen: assert property (@(posedge clk) disable iff (!resetn)
		!cnt_en && !wr_counter |=> $stable(counter));

endmodule

`default_nettype wire

//--- rtl/periph_top.sv
// Peripheral top level joining the AXI4-Lite slave to the register file, the DUT of the testbench
`timescale 1ns/1ps
`default_nettype none

module periph_top
	import axil_pkg::*;
	import regmap_pkg::*;
(
	input  wire             clk,
	input  wire             resetn,
	input  wire axil_req_t  axi_req,
	output axil_rsp_t       axi_rsp
);

	reg_wr_t               wr_req;
	logic [REG_IDX_W-1:0]  rd_idx;
	logic [REG_DATA_W-1:0] rd_data;

	axi_lite_slave u_slave (
		.clk     (clk),
		.resetn  (resetn),
		.axi_req (axi_req),
		.axi_rsp (axi_rsp),
		.wr_req  (wr_req),
		.rd_idx  (rd_idx),
		.rd_data (rd_data)
	);

	reg_file u_regs (
		.clk     (clk),
		.resetn  (resetn),
		.wr_req  (wr_req),
		.rd_idx  (rd_idx),
		.rd_data (rd_data)
	);

endmodule

`default_nettype wire

//--- tests/tb_periph_top.sv
// Directed testbench for periph_top; run it with the sources listed in sim.f
`timescale 1ns/1ps
`default_nettype none

module tb_periph_top
	import axil_pkg::*;
	import regmap_pkg::*;
();

	localparam int WAIT_LIMIT = 50;

	// Selectors for the slave handshake flags
	localparam int F_AWREADY = 0;
	localparam int F_WREADY  = 1;
	localparam int F_BVALID  = 2;
	localparam int F_ARREADY = 3;
	localparam int F_RVALID  = 4;

	localparam logic [AXIL_ADDR_W-1:0] A_ID      = {REG_ID, 2'b00};
	localparam logic [AXIL_ADDR_W-1:0] A_SCRATCH = {REG_SCRATCH, 2'b00};
	localparam logic [AXIL_ADDR_W-1:0] A_CONTROL = {REG_CONTROL, 2'b00};
	localparam logic [AXIL_ADDR_W-1:0] A_COUNTER = {REG_COUNTER, 2'b00};

	logic      clk;
	logic      resetn;
	axil_req_t axi_req;
	axil_rsp_t axi_rsp;

	string       test_name;
	logic [31:0] rng_state;
	logic [31:0] scratch_model;

	periph_top uut (
		.clk     (clk),
		.resetn  (resetn),
		.axi_req (axi_req),
		.axi_rsp (axi_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Expected register value after a strobed write
	function automatic logic [31:0] strobe_merge(input logic [31:0] old_val,
			input logic [31:0] new_val, input logic [3:0] strb);
		logic [31:0] mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old_val & ~mask) | (new_val & mask);
	endfunction

	function automatic logic rsp_flag(input int which);
		case (which)
			F_AWREADY: return axi_rsp.awready;
			F_WREADY:  return axi_rsp.wready;
			F_BVALID:  return axi_rsp.bvalid;
			F_ARREADY: return axi_rsp.arready;
			F_RVALID:  return axi_rsp.rvalid;
			default:   return 1'b0;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "value check failed");
		end
	endtask

	// Called on a falling edge and returns on the falling edge where the flag is high
	task automatic wait_flag(input int which, input string what);
		int cycles;
		cycles = 0;
		while (!rsp_flag(which)) begin
			if (cycles >= WAIT_LIMIT) begin
				$display("TIMEOUT in %s: %s never went high within %0d cycles",
					test_name, what, WAIT_LIMIT);
				$display("FAIL: see errors above");
				$fatal(1, "handshake timed out");
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	// bready is held low for hold cycles once bvalid is seen
	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input int hold, output logic [1:0] resp);
		int i;
		axi_req.awaddr  = addr;
		axi_req.awvalid = 1'b1;
		axi_req.wdata   = data;
		axi_req.wstrb   = strb;
		axi_req.wvalid  = 1'b1;
		axi_req.bready  = 1'b0;
		@(negedge clk);
		wait_flag(F_AWREADY, "awready");
		@(negedge clk);
		axi_req.awvalid = 1'b0;
		wait_flag(F_WREADY, "wready");
		@(negedge clk);
		axi_req.wvalid = 1'b0;
		wait_flag(F_BVALID, "bvalid");
		resp = axi_rsp.bresp;
		for (i = 0; i < hold; i++) begin
			@(negedge clk);
			check({test_name, " bvalid"}, 32'd1, axi_rsp.bvalid);
			check({test_name, " bresp"}, RESP_OKAY, axi_rsp.bresp);
		end
		axi_req.bready = 1'b1;
		@(negedge clk);
		axi_req.bready = 1'b0;
	endtask

	// rready is held low for hold cycles once rvalid is seen
	task automatic axil_read(input logic [3:0] addr, input int hold,
			output logic [31:0] data);
		int i;
		axi_req.araddr  = addr;
		axi_req.arvalid = 1'b1;
		axi_req.rready  = 1'b0;
		@(negedge clk);
		wait_flag(F_ARREADY, "arready");
		@(negedge clk);
		axi_req.arvalid = 1'b0;
		wait_flag(F_RVALID, "rvalid");
		data = axi_rsp.rdata;
		check({test_name, " rresp"}, RESP_OKAY, axi_rsp.rresp);
		for (i = 0; i < hold; i++) begin
			@(negedge clk);
			check({test_name, " rvalid"}, 32'd1, axi_rsp.rvalid);
			check({test_name, " rdata"}, data, axi_rsp.rdata);
		end
		axi_req.rready = 1'b1;
		@(negedge clk);
		axi_req.rready = 1'b0;
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		logic [1:0] resp;
		axil_write(addr, data, strb, 0, resp);
		check({test_name, " bresp"}, RESP_OKAY, resp);
	endtask

	task automatic expect_reg(input logic [3:0] addr, input logic [31:0] expected);
		logic [31:0] data;
		axil_read(addr, 0, data);
		check(test_name, expected, data);
	endtask

	task automatic test_reset_id();
		test_name = "reset_id";
		expect_reg(A_ID, ID_VALUE);
		expect_reg(A_SCRATCH, 32'd0);
		expect_reg(A_CONTROL, 32'd0);
		expect_reg(A_COUNTER, 32'd0);
	endtask

	task automatic test_scratch_strobes();
		logic [31:0] wdata;
		logic [3:0]  strb_list [3];
		test_name = "scratch_strobes";
		strb_list = '{4'b0101, 4'b1000, 4'b0110};
		scratch_model = next_random();
		write_reg(A_SCRATCH, scratch_model, 4'hf);
		expect_reg(A_SCRATCH, scratch_model);
		foreach (strb_list[i]) begin
			wdata = next_random();
			write_reg(A_SCRATCH, wdata, strb_list[i]);
			scratch_model = strobe_merge(scratch_model, wdata, strb_list[i]);
			expect_reg(A_SCRATCH, scratch_model);
		end
		// Zero strobe still gets OKAY
		write_reg(A_SCRATCH, next_random(), 4'h0);
		expect_reg(A_SCRATCH, scratch_model);
	endtask

	task automatic test_id_readonly();
		test_name = "id_readonly";
		write_reg(A_ID, next_random(), 4'hf);
		expect_reg(A_ID, ID_VALUE);
	endtask

	task automatic test_counter();
		logic [31:0] start;
		logic [31:0] first;
		logic [31:0] second;
		test_name = "counter";
		write_reg(A_CONTROL, 32'd0, 4'hf);
		// Keep clear of wrap-around
		start = next_random() & 32'h0fff_ffff;
		write_reg(A_COUNTER, start, 4'hf);
		expect_reg(A_COUNTER, start);
		expect_reg(A_COUNTER, start);
		write_reg(A_CONTROL, 32'd1 << CTRL_CNT_EN_BIT, 4'hf);
		axil_read(A_COUNTER, 0, first);
		check({test_name, " running"}, 32'd1, first > start);
		write_reg(A_CONTROL, 32'd0, 4'hf);
		axil_read(A_COUNTER, 0, first);
		axil_read(A_COUNTER, 0, second);
		check({test_name, " frozen"}, first, second);
	endtask

	task automatic test_backpressure();
		logic [1:0]  resp;
		logic [31:0] data;
		test_name = "backpressure";
		scratch_model = next_random();
		axil_write(A_SCRATCH, scratch_model, 4'hf, 5, resp);
		check({test_name, " bresp"}, RESP_OKAY, resp);
		axil_read(A_SCRATCH, 5, data);
		check(test_name, scratch_model, data);
	endtask

	task automatic test_concurrency();
		logic [1:0]  resp;
		logic [31:0] data;
		logic [31:0] ctrl_val;
		test_name = "concurrency";
		// Counter stays disabled
		ctrl_val = next_random() & ~(32'd1 << CTRL_CNT_EN_BIT);
		fork
			axil_write(A_CONTROL, ctrl_val, 4'hf, 0, resp);
			begin
				@(negedge clk);
				axil_read(A_SCRATCH, 0, data);
			end
		join
		check({test_name, " bresp"}, RESP_OKAY, resp);
		check({test_name, " old scratch"}, scratch_model, data);
		expect_reg(A_CONTROL, ctrl_val);
	endtask

	initial begin
		axi_req       = '0;
		resetn        = 1'b0;
		rng_state     = 32'hf543;
		scratch_model = '0;
		test_name     = "reset";
		repeat (4) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
		test_reset_id();
		test_scratch_strobes();
		test_id_readonly();
		test_counter();
		test_backpressure();
		test_concurrency();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
common/axil_pkg.sv
common/regmap_pkg.sv
axi_lite_slave/axi_lite_slave.sv
rtl/reg_file.sv
rtl/periph_top.sv
tests/tb_periph_top.sv

//--- Bender.yml
package:
  name: periph_axil

sources:
  - files:
      - common/axil_pkg.sv
      - common/regmap_pkg.sv
      - axi_lite_slave/axi_lite_slave.sv
      - rtl/reg_file.sv
      - rtl/periph_top.sv
  - target: test
    files:
      - tests/tb_periph_top.sv
